/* dv/tb_vga_display.sv */
// self-checking testbench for vga_display; runs two full frames (about 1.67M clocks) and stops at the first error
`include "vga_cfg.svh"

module tb_vga_display
    import vga_timing_pkg::*;
    import vga_color_pkg::*;
();

    localparam int FRAME_CLOCKS   = `H_TOTAL * `V_TOTAL;
    // each table entry stays on the inputs for half a frame
    localparam int HOLD_CLOCKS    = FRAME_CLOCKS / 2;
    localparam int NUM_ENTRIES    = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * HOLD_CLOCKS + 2000;
    // checker cell side in pixels
    localparam int CELL           = 1 << `CHECKER_SHIFT;

    logic       clk;
    logic       reset;
    pixel_row_t box_row;
    pixel_col_t box_col;
    color_t     box_color;
    color_t     color_a;
    color_t     color_b;
    channel_t   red;
    channel_t   green;
    channel_t   blue;
    logic       hs;
    logic       vs;

    // stimulus table, one column per DUT input
    pixel_row_t tbl_box_row   [NUM_ENTRIES];
    pixel_col_t tbl_box_col   [NUM_ENTRIES];
    color_t     tbl_box_color [NUM_ENTRIES];
    color_t     tbl_color_a   [NUM_ENTRIES];
    color_t     tbl_color_b   [NUM_ENTRIES];

    integer      seed;
    int          cycle_count = 0;
    // reference counters, the counts the DUT holds during the current clock
    int          m_col;
    int          m_row;
    // counts that the outputs after the next edge reflect
    int          obs_col;
    int          obs_row;
    int          hs_low_clocks;
    int          vs_low_clocks;
    logic [11:0] exp_color;
    logic        exp_hs;
    logic        exp_vs;

    vga_display dut (
        .clk       (clk),
        .reset     (reset),
        .box_row   (box_row),
        .box_col   (box_col),
        .box_color (box_color),
        .color_a   (color_a),
        .color_b   (color_b),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .hs        (hs),
        .vs        (vs)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // hard stop in case the run never reaches its end
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d clocks", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h at cycle %0d",
                     name, got, exp, cycle_count);
            $display("TESTS FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic fill_table();
        integer rnd;
        // ordinary square well inside the screen
        tbl_box_row[0]   = 10'd100;
        tbl_box_col[0]   = 10'd200;
        tbl_box_color[0] = 12'hF00;
        tbl_color_a[0]   = 12'h222;
        tbl_color_b[0]   = 12'hDDD;
        // square hanging over the right and bottom edges
        tbl_box_row[1]   = 10'd470;
        tbl_box_col[1]   = 10'd630;
        tbl_box_color[1] = 12'h0F0;
        tbl_color_a[1]   = 12'h00F;
        tbl_color_b[1]   = 12'hFF0;
        // top left corner, random colors
        tbl_box_row[2]   = 10'd0;
        tbl_box_col[2]   = 10'd0;
        rnd              = $random(seed);
        tbl_box_color[2] = rnd[11:0];
        rnd              = $random(seed);
        tbl_color_a[2]   = rnd[11:0];
        rnd              = $random(seed);
        tbl_color_b[2]   = rnd[11:0];
        // square that just fits the bottom right corner
        tbl_box_row[3]   = 10'd448;
        tbl_box_col[3]   = 10'd608;
        tbl_box_color[3] = 12'h0FF;
        tbl_color_a[3]   = 12'hF0F;
        tbl_color_b[3]   = 12'h123;
    endtask

    task automatic drive_entry(input int e);
        box_row   = tbl_box_row[e];
        box_col   = tbl_box_col[e];
        box_color = tbl_box_color[e];
        color_a   = tbl_color_a[e];
        color_b   = tbl_color_b[e];
    endtask

    // square test in plain integers, so nothing can wrap
    function automatic logic in_square(input int c_cnt, input int r_cnt, input int e);
        int px;
        int py;
        int br;
        int bc;
        px = c_cnt / 2;
        py = r_cnt;
        br = int'(tbl_box_row[e]);
        bc = int'(tbl_box_col[e]);
        return (py >= br) && (py < br + `BOX_SIZE) && (px >= bc) && (px < bc + `BOX_SIZE);
    endfunction

    function automatic logic [11:0] expected_color(input int c_cnt, input int r_cnt,
                                                   input int e);
        int px;
        int py;
        if (c_cnt >= `H_DISPLAY || r_cnt >= `V_DISPLAY) begin
            return 12'h000;
        end
        px = c_cnt / 2;
        py = r_cnt;
        if (in_square(c_cnt, r_cnt, e)) begin
            return tbl_box_color[e];
        end
        // odd cell sum means the second color
        if (((py / CELL) + (px / CELL)) % 2 == 1) begin
            return tbl_color_b[e];
        end
        return tbl_color_a[e];
    endfunction

    // expected outputs after the next edge, then step the reference counters
    task automatic predict_next(input int e);
        obs_col   = m_col;
        obs_row   = m_row;
        exp_color = expected_color(m_col, m_row, e);
        exp_hs    = !(m_col >= `H_SYNC_START && m_col <= `H_SYNC_END);
        exp_vs    = !(m_row >= `V_SYNC_START && m_row <= `V_SYNC_END);
        if (m_col == `H_TOTAL - 1) begin
            m_col = 0;
            if (m_row == `V_TOTAL - 1) begin
                m_row = 0;
            end else begin
                m_row = m_row + 1;
            end
        end else begin
            m_col = m_col + 1;
        end
    endtask

    task automatic compare_outputs();
        check_value("red", 32'(red), 32'(exp_color[11:8]));
        check_value("green", 32'(green), 32'(exp_color[7:4]));
        check_value("blue", 32'(blue), 32'(exp_color[3:0]));
        check_value("hs", 32'(hs), 32'(exp_hs));
        check_value("vs", 32'(vs), 32'(exp_vs));
    endtask

    // pulse widths per line and per frame, on top of the per-clock compare
    task automatic count_sync();
        if (!hs) begin
            hs_low_clocks = hs_low_clocks + 1;
        end
        if (!vs) begin
            vs_low_clocks = vs_low_clocks + 1;
        end
        if (obs_col == `H_TOTAL - 1) begin
            check_value("hs low clocks per line", hs_low_clocks,
                        `H_SYNC_END - `H_SYNC_START + 1);
            hs_low_clocks = 0;
            if (obs_row == `V_TOTAL - 1) begin
                check_value("vs low clocks per frame", vs_low_clocks,
                            (`V_SYNC_END - `V_SYNC_START + 1) * `H_TOTAL);
                vs_low_clocks = 0;
            end
        end
    endtask

    initial begin
        int e;
        int n;
        reset     = 1'b1;
        box_row   = '0;
        box_col   = '0;
        box_color = '0;
        color_a   = '0;
        color_b   = '0;
        seed      = 32'h5999;
        fill_table();
        // idle levels while reset is held
        exp_color = 12'h000;
        exp_hs    = 1'b1;
        exp_vs    = 1'b1;
        for (n = 0; n < RESET_CYCLES; n++) begin
            @(posedge clk);
            #1;
            compare_outputs();
        end
        reset         = 1'b0;
        m_col         = 0;
        m_row         = 0;
        hs_low_clocks = 0;
        vs_low_clocks = 0;
        for (e = 0; e < NUM_ENTRIES; e++) begin
            // new entry lands 1 unit after an edge, seen at the next edge
            drive_entry(e);
            for (n = 0; n < HOLD_CLOCKS; n++) begin
                predict_next(e);
                @(posedge clk);
                #1;
                compare_outputs();
                count_sync();
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+source
source/vga_timing_pkg.sv
source/vga_color_pkg.sv
source/vga_sync.sv
source/pattern_painter.sv
source/pixel_output.sv
source/vga_display.sv
dv/tb_vga_display.sv

/* run_sim.sh */
#!/bin/sh
# build and run the vga_display testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --top-module tb_vga_display -Mdir "$OBJ" -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/Vtb_vga_display" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in $LOG"
exit 1

/* source/pattern_painter.sv */
// purely combinational; ignores blank, so its output is only meaningful on visible pixels
`include "vga_cfg.svh"

module pattern_painter
    import vga_timing_pkg::*;
    import vga_color_pkg::*;
(
    input  pixel_row_t row,
    input  pixel_col_t col,
    input  pixel_row_t box_row,
    input  pixel_col_t box_col,
    input  color_t     box_color,
    input  color_t     color_a,
    input  color_t     color_b,
    output color_t     pixel_color
);

    // one extra bit so a square near the bottom or right edge
    // does not wrap its far side around to row or column 0
    localparam int ROW_EXT_W = $bits(pixel_row_t) + 1;
    localparam int COL_EXT_W = $bits(pixel_col_t) + 1;

    logic [ROW_EXT_W-1:0] row_ext;
    logic [COL_EXT_W-1:0] col_ext;
    logic [ROW_EXT_W-1:0] box_row_end;
    logic [COL_EXT_W-1:0] box_col_end;
    logic                 in_box_rows;
    logic                 in_box_cols;
    logic                 in_box;
    logic                 checker_sel;
    color_t               checker_color;

    // zero-extend the current pixel to match the end bounds
    assign row_ext = {1'b0, row};
    assign col_ext = {1'b0, col};

    // first row and column past the square
    assign box_row_end = {1'b0, box_row} + ROW_EXT_W'(`BOX_SIZE);
    assign box_col_end = {1'b0, box_col} + COL_EXT_W'(`BOX_SIZE);

    // half-open range test on each axis
    // lower bound inclusive, upper bound exclusive
    assign in_box_rows = (row >= box_row) && (row_ext < box_row_end);
    assign in_box_cols = (col >= box_col) && (col_ext < box_col_end);
    assign in_box      = in_box_rows && in_box_cols;

    // checker cell parity
    // the bit at CHECKER_SHIFT flips once per cell along each axis
    assign checker_sel = row[`CHECKER_SHIFT] ^ col[`CHECKER_SHIFT];

    always_comb begin
        // even cells take color_a, odd cells color_b
        if (checker_sel) begin
            checker_color = color_b;
        end else begin
            checker_color = color_a;
        end
    end

    always_comb begin
        // the square is drawn over the background
        if (in_box) begin
            pixel_color = box_color;
        end else begin
            pixel_color = checker_color;
        end
    end

endmodule

/* source/pixel_output.sv */
// one register stage for color, hs and vs; color is forced to black whenever blank is high
module pixel_output
    import vga_color_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  color_t   pixel_color,
    input  logic     blank,
    input  logic     hs_raw,
    input  logic     vs_raw,
    output channel_t red,
    output channel_t green,
    output channel_t blue,
    output logic     hs,
    output logic     vs
);

    color_t color_q;
    color_t color_d;

    // monitors expect zero drive outside the display area
    assign color_d = blank ? COLOR_BLACK : pixel_color;

    // color and sync are registered together so the sync edges
    // line up with the pixel data at the pins
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            color_q <= COLOR_BLACK;
            // sync pulses are active low, so idle high
            hs      <= 1'b1;
            vs      <= 1'b1;
        end else begin
            color_q <= color_d;
            hs      <= hs_raw;
            vs      <= vs_raw;
        end
    end

    // split the packed color into the three DAC channels
    assign red   = color_red(color_q);
    assign green = color_green(color_q);
    assign blue  = color_blue(color_q);

endmodule

/* source/vga_cfg.svh */
// 640x480 timing at a 50 MHz clock (two clocks per pixel); other modes are not supported
`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

// horizontal timing, in clocks of the 50 MHz system clock
// display 0-1279, front porch 1280-1311, sync 1312-1503, back porch 1504-1599
`define H_TOTAL       1600
`define H_DISPLAY     1280
// hs is low from sync start through sync end, both inclusive
`define H_SYNC_START  1312
`define H_SYNC_END    1503

// vertical timing, in lines
// display 0-479, front porch 480-489, sync 490-491, back porch 492-520
`define V_TOTAL       521
`define V_DISPLAY     480
// vs is low from sync start through sync end, both inclusive
`define V_SYNC_START  490
`define V_SYNC_END    491

// side of the solid square, in visible pixels
`define BOX_SIZE      32

// checker cells are 2**CHECKER_SHIFT pixels on a side
// the painter uses this as a bit index into row and col
`define CHECKER_SHIFT 4

`endif

/* source/vga_color_pkg.sv */
// 4 bits per channel only; color_t packs red, green, blue from the top bits down
package vga_color_pkg;

    // bits per channel, matching a 4-bit resistor DAC per color
    localparam int CHANNEL_W = 4;

    // intensity of one channel
    // 0 is off, all ones is full drive
    typedef logic [CHANNEL_W-1:0] channel_t;

    // packed color
    //   [11:8] red
    //   [7:4]  green
    //   [3:0]  blue
    typedef logic [3*CHANNEL_W-1:0] color_t;

    // black, which is also what the monitor must see during blanking
    localparam color_t COLOR_BLACK = '0;

    // channel extraction
    // red sits in the top channel
    function automatic channel_t color_red(input color_t c);
        return c[3*CHANNEL_W-1 -: CHANNEL_W];
    endfunction

    function automatic channel_t color_green(input color_t c);
        return c[2*CHANNEL_W-1 -: CHANNEL_W];
    endfunction

    // blue sits in the bottom channel
    function automatic channel_t color_blue(input color_t c);
        return c[CHANNEL_W-1:0];
    endfunction

endpackage

/* source/vga_display.sv */
// 640x480 VGA top at a 50 MHz clock; outputs lag counters and inputs by exactly one clock
module vga_display
    import vga_timing_pkg::*;
    import vga_color_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  pixel_row_t box_row,
    input  pixel_col_t box_col,
    input  color_t     box_color,
    input  color_t     color_a,
    input  color_t     color_b,
    output channel_t   red,
    output channel_t   green,
    output channel_t   blue,
    output logic       hs,
    output logic       vs
);

    // combinational decode of the current counts
    pixel_row_t row;
    pixel_col_t col;
    logic       hs_raw;
    logic       vs_raw;
    logic       blank;
    // painter result for the current pixel, before blanking
    color_t     pixel_color;

    // line and frame counters plus sync decode
    vga_sync u_sync (
        .clk    (clk),
        .reset  (reset),
        .row    (row),
        .col    (col),
        .hs_raw (hs_raw),
        .vs_raw (vs_raw),
        .blank  (blank)
    );

    // checkerboard background with the square on top
    pattern_painter u_painter (
        .row         (row),
        .col         (col),
        .box_row     (box_row),
        .box_col     (box_col),
        .box_color   (box_color),
        .color_a     (color_a),
        .color_b     (color_b),
        .pixel_color (pixel_color)
    );

    // blank mask and the single output register stage
    pixel_output u_output (
        .clk         (clk),
        .reset       (reset),
        .pixel_color (pixel_color),
        .blank       (blank),
        .hs_raw      (hs_raw),
        .vs_raw      (vs_raw),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .hs          (hs),
        .vs          (vs)
    );

endmodule

/* source/vga_sync.sv */
// 640x480 sync generator for a 50 MHz clock; all outputs are combinational decodes of the counters
`include "vga_cfg.svh"

module vga_sync
    import vga_timing_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output pixel_row_t row,
    output pixel_col_t col,
    output logic       hs_raw,
    output logic       vs_raw,
    output logic       blank
);

    h_count_t col_count;
    logic     col_clear;
    v_count_t row_count;
    logic     row_clear;
    logic     row_enable;
    logic     h_blank;
    logic     v_blank;

    // column counter
    // runs every clock, wraps from 1599 back to 0
    assign col_clear = (col_count >= h_count_t'(`H_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            col_count <= '0;
        end else if (col_clear) begin
            // wrap at the end of the line
            col_count <= '0;
        end else begin
            col_count <= col_count + 1'b1;
        end
    end

    // row counter
    // steps once per line, on the last column clock
    assign row_enable = (col_count == h_count_t'(`H_TOTAL - 1));
    // wrap only at the end of the last line, so line 520 lasts a full line
    assign row_clear  = row_enable && (row_count >= v_count_t'(`V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            row_count <= '0;
        end else if (row_clear) begin
            row_count <= '0;
        end else if (row_enable) begin
            row_count <= row_count + 1'b1;
        end
    end

    // visible coordinates
    // two clocks per pixel, so drop the lsb of the column count
    assign row = row_count;
    assign col = col_count[10:1];

    // active-low sync pulses, inclusive ranges
    assign hs_raw = (col_count < h_count_t'(`H_SYNC_START)) ||
                    (col_count > h_count_t'(`H_SYNC_END));
    assign vs_raw = (row_count < v_count_t'(`V_SYNC_START)) ||
                    (row_count > v_count_t'(`V_SYNC_END));

    // blanking covers porches and sync in both directions
    assign h_blank = (col_count >= h_count_t'(`H_DISPLAY));
    assign v_blank = (row_count >= v_count_t'(`V_DISPLAY));
    assign blank   = h_blank || v_blank;

endmodule

/* source/vga_timing_pkg.sv */
// counter and coordinate widths sized for 1600 clocks per line and 521 lines per frame only
package vga_timing_pkg;

    // column clock counter, 0 to 1599
    // two clocks per pixel, so one bit wider than a column
    typedef logic [10:0] h_count_t;

    // line counter, 0 to 520
    typedef logic [9:0] v_count_t;

    // visible row, 0 to 479 while not blanked
    // outside the display area it still follows the line count
    typedef logic [9:0] pixel_row_t;

    // visible column, 0 to 639 while not blanked
    // this is the column clock count divided by 2
    typedef logic [9:0] pixel_col_t;

endpackage
